// File: Makefile
# Verilator build and run for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= branch_predictor.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: branch_predictor.f
rtl/fetch_pkg.sv
rtl/bp_state_pkg.sv
rtl/bht.sv
rtl/btb.sv
rtl/next_pc_sel.sv
rtl/branch_predictor.sv
verif/branch_predictor_sva.sv
verif/tb_branch_predictor.sv

// File: rtl/bht.sv
// ------------------------------
// branch history table, 2-bit counters
// BHT_ENTRIES must be a power of two
// read is combinational, update lands next cycle
// ------------------------------
`timescale 1ns/1ps

module bht #(
    parameter int BHT_ENTRIES = 256
) (
    input  logic                    clk,
    input  logic                    rst,
    input  fetch_pkg::pc_t          fetch_pc,
    input  bp_state_pkg::resolve_t  resolve,
    output bp_state_pkg::ctr_t      ctr
);

    localparam int IDX_W = $clog2(BHT_ENTRIES);

    bp_state_pkg::ctr_t     ctr_mem [BHT_ENTRIES];  // counter storage
    logic [BHT_ENTRIES-1:0] valid_q;                // cleared on reset

    logic [IDX_W-1:0]   rd_idx;
    logic [IDX_W-1:0]   wr_idx;
    logic               upd_en;
    bp_state_pkg::ctr_t old_ctr;
    bp_state_pkg::ctr_t new_ctr;

    // word address bits, byte offset dropped
    assign rd_idx = fetch_pc[IDX_W+1:2];
    assign wr_idx = resolve.pc[IDX_W+1:2];

    // cold entry looks like weak not taken
    assign ctr = valid_q[rd_idx] ? ctr_mem[rd_idx] : bp_state_pkg::ctr_wnt;

    // only conditional branches train the counters
    assign upd_en = resolve.valid && (resolve.kind == fetch_pkg::br_cond);

    // first update starts from weak not taken
    assign old_ctr = valid_q[wr_idx] ? ctr_mem[wr_idx] : bp_state_pkg::ctr_wnt;

    // one step toward the outcome, saturating at the ends
    always_comb begin
        new_ctr = old_ctr;
        case (old_ctr)
            bp_state_pkg::ctr_snt: begin
                new_ctr = resolve.taken ? bp_state_pkg::ctr_wnt : bp_state_pkg::ctr_snt;
            end
            bp_state_pkg::ctr_wnt: begin
                new_ctr = resolve.taken ? bp_state_pkg::ctr_wt : bp_state_pkg::ctr_snt;
            end
            bp_state_pkg::ctr_wt: begin
                new_ctr = resolve.taken ? bp_state_pkg::ctr_st : bp_state_pkg::ctr_wnt;
            end
            bp_state_pkg::ctr_st: begin
                new_ctr = resolve.taken ? bp_state_pkg::ctr_st : bp_state_pkg::ctr_wt;
            end
            default: begin
                new_ctr = bp_state_pkg::ctr_wnt;
            end
        endcase
    end

    // valid bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (upd_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // counter array, contents meaningless until valid
    always_ff @(posedge clk) begin
        if (upd_en) begin
            ctr_mem[wr_idx] <= new_ctr;
        end
    end

endmodule

// File: rtl/bp_state_pkg.sv
// ------------------------------
// prediction side types
// resolve_t carries the prediction made at fetch
// down the pipe, so execute can flag mispredicts
// ------------------------------

package bp_state_pkg;

    // 2-bit saturating counter with the taken guess in the msb
    typedef enum logic [1:0] {
        ctr_snt = 2'b00,    // strong not taken
        ctr_wnt = 2'b01,    // weak not taken and the cold value
        ctr_wt  = 2'b10,    // weak taken
        ctr_st  = 2'b11     // strong taken
    } ctr_t;

    // prediction for the current fetch pc (33 bits)
    typedef struct packed {
        logic             taken;
        fetch_pkg::pc_t   target;   // pc+4 when not taken
    } pred_t;

    // resolved instruction from execute (101 bits)
    typedef struct packed {
        logic                  valid;       // one cycle strobe
        fetch_pkg::pc_t        pc;          // pc of the branch itself
        fetch_pkg::br_kind_t   kind;
        logic                  taken;       // actual outcome
        fetch_pkg::pc_t        target;      // actual target
        logic                  pred_taken;  // what fetch guessed
        fetch_pkg::pc_t        pred_target;
    } resolve_t;

endpackage

// File: rtl/branch_predictor.sv
// ------------------------------
// branch prediction front end, top level
// table depths set here, powers of two
// ------------------------------
`timescale 1ns/1ps

module branch_predictor #(
    parameter int BHT_ENTRIES = 256,
    parameter int BTB_ENTRIES = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  bp_state_pkg::resolve_t  resolve,    // from execute
    output fetch_pkg::pc_t          fetch_pc,
    output bp_state_pkg::pred_t     pred
);

    bp_state_pkg::ctr_t     bht_ctr;
    logic                   btb_hit;
    fetch_pkg::pc_t         btb_target;
    fetch_pkg::br_kind_t    btb_kind;

    // direction
    bht #(
        .BHT_ENTRIES (BHT_ENTRIES)
    ) u_bht (
        .clk      (clk),
        .rst      (rst),
        .fetch_pc (fetch_pc),
        .resolve  (resolve),
        .ctr      (bht_ctr)
    );

    // target and kind
    btb #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_btb (
        .clk      (clk),
        .rst      (rst),
        .fetch_pc (fetch_pc),
        .resolve  (resolve),
        .hit      (btb_hit),
        .target   (btb_target),
        .kind     (btb_kind)
    );

    next_pc_sel u_next_pc_sel (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .resolve    (resolve),
        .btb_hit    (btb_hit),
        .btb_target (btb_target),
        .btb_kind   (btb_kind),
        .ctr        (bht_ctr),
        .fetch_pc   (fetch_pc),
        .pred       (pred)
    );

endmodule

// File: rtl/btb.sv
// ------------------------------
// direct mapped branch target buffer
// BTB_ENTRIES must be a power of two
// not-taken conditionals never allocate
// ------------------------------
`timescale 1ns/1ps

module btb #(
    parameter int BTB_ENTRIES = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  fetch_pkg::pc_t          fetch_pc,
    input  bp_state_pkg::resolve_t  resolve,
    output logic                    hit,
    output fetch_pkg::pc_t          target,
    output fetch_pkg::br_kind_t     kind
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 32 - IDX_W - 2;  // everything above the index

    // entry storage, no reset on payload
    logic [TAG_W-1:0]       tag_mem    [BTB_ENTRIES];
    fetch_pkg::pc_t         target_mem [BTB_ENTRIES];
    fetch_pkg::br_kind_t    kind_mem   [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid_q;

    logic [IDX_W-1:0]   rd_idx;
    logic [TAG_W-1:0]   rd_tag;
    logic [IDX_W-1:0]   wr_idx;
    logic [TAG_W-1:0]   wr_tag;
    logic               wr_en;

    // split the fetch pc into index and tag
    assign rd_idx = fetch_pc[IDX_W+1:2];
    assign rd_tag = fetch_pc[31:IDX_W+2];

    assign wr_idx = resolve.pc[IDX_W+1:2];
    assign wr_tag = resolve.pc[31:IDX_W+2];

    // lookup
    assign hit    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign target = target_mem[rd_idx];
    assign kind   = kind_mem[rd_idx];

    // allocate on jumps and taken conditionals
    // a not-taken branch keeps its entry so the bht can steer it
    always_comb begin
        wr_en = 1'b0;
        if (resolve.valid) begin
            case (resolve.kind)
                fetch_pkg::br_jump: wr_en = 1'b1;
                fetch_pkg::br_cond: wr_en = resolve.taken;
                default:            wr_en = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // overwrite on conflict, last writer wins
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= resolve.target;
            kind_mem[wr_idx]   <= resolve.kind;
        end
    end

endmodule

// File: rtl/fetch_pkg.sv
// ------------------------------
// fetch side types for the predictor
// pc is a byte address, fetch is word aligned
// reset vector is fixed here, not a port
// ------------------------------

package fetch_pkg;

    // 32-bit byte address
    typedef logic [31:0] pc_t;

    // first fetch after reset
    localparam pc_t RESET_PC = 32'h0000_1000;

    // kind of control transfer as recorded in the btb
    typedef enum logic [1:0] {
        br_none = 2'b00,    // not a branch
        br_cond = 2'b01,    // conditional and steered by the bht
        br_jump = 2'b10     // unconditional and always taken
    } br_kind_t;

endpackage

// File: rtl/next_pc_sel.sv
// ------------------------------
// fetch pc register and next pc mux
// redirect beats stall, one cycle latency
// prediction is combinational on fetch_pc
// ------------------------------
`timescale 1ns/1ps

module next_pc_sel (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  bp_state_pkg::resolve_t  resolve,
    input  logic                    btb_hit,
    input  fetch_pkg::pc_t          btb_target,
    input  fetch_pkg::br_kind_t     btb_kind,
    input  bp_state_pkg::ctr_t      ctr,
    output fetch_pkg::pc_t          fetch_pc,
    output bp_state_pkg::pred_t     pred
);

    logic           mispredict;
    fetch_pkg::pc_t correct_pc;
    fetch_pkg::pc_t seq_pc;
    fetch_pkg::pc_t pc_d;

    assign seq_pc = fetch_pc + 32'd4;

    // jump hits always taken, cond hits follow the counter msb
    always_comb begin
        pred.taken  = 1'b0;
        pred.target = seq_pc;
        if (btb_hit) begin
            if (btb_kind == fetch_pkg::br_jump) begin
                pred.taken  = 1'b1;
                pred.target = btb_target;
            end else if (btb_kind == fetch_pkg::br_cond && ctr[1]) begin
                pred.taken  = 1'b1;
                pred.target = btb_target;
            end
        end
    end

    // compare the outcome with the guess carried from fetch
    // target only matters on a taken branch
    assign mispredict = resolve.valid &&
                        ((resolve.taken != resolve.pred_taken) ||
                         (resolve.taken && (resolve.target != resolve.pred_target)));

    assign correct_pc = resolve.taken ? resolve.target : resolve.pc + 32'd4;

    // redirect first, then stall, predicted, sequential
    always_comb begin
        if (mispredict) begin
            pc_d = correct_pc;
        end else if (stall) begin
            pc_d = fetch_pc;
        end else if (pred.taken) begin
            pc_d = pred.target;
        end else begin
            pc_d = seq_pc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_pc <= fetch_pkg::RESET_PC;
        end else begin
            fetch_pc <= pc_d;
        end
    end

endmodule

// File: verif/branch_predictor_sva.sv
// ------------------------------
// port level checks, bound into the top
// mispredict rebuilt here from resolve
// ------------------------------
`timescale 1ns/1ps

module branch_predictor_sva (
    input logic                    clk,
    input logic                    rst,
    input logic                    stall,
    input bp_state_pkg::resolve_t  resolve,
    input fetch_pkg::pc_t          fetch_pc,
    input bp_state_pkg::pred_t     pred
);

    logic mispredict;

    // wrong direction, or taken to the wrong place
    assign mispredict = resolve.valid &&
                        ((resolve.taken != resolve.pred_taken) ||
                         (resolve.taken && (resolve.target != resolve.pred_target)));

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        fetch_pc[1:0] == 2'b00)
        else $error("fetch_pc %h not word aligned", fetch_pc);

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (stall && !mispredict) |=> (fetch_pc == $past(fetch_pc)))
        else $error("fetch_pc moved under stall without a redirect");

    a_cold_pred: assert property (@(posedge clk)
        $fell(rst) |-> !pred.taken)     // tables empty right after reset
        else $error("pred.taken set in the first cycle after reset");

endmodule

bind branch_predictor branch_predictor_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .resolve  (resolve),
    .fetch_pc (fetch_pc),
    .pred     (pred)
);

// File: verif/tb_branch_predictor.sv
// ------------------------------
// testbench for the branch predictor top
// model assumes default depths 256 / 64
// rows driven on falling edges, checked before drive
// ------------------------------
`timescale 1ns/1ps

module tb_branch_predictor;

    localparam int BHT_N  = 256;    // dut default depths
    localparam int BTB_N  = 64;
    localparam int N_RAND = 24;

    // what a row compares
    localparam int CHK_NONE = 0;
    localparam int CHK_PC   = 1;
    localparam int CHK_ALL  = 2;

    localparam fetch_pkg::pc_t P_COND  = 32'h0000_1100;  // btb idx 0
    localparam fetch_pkg::pc_t T_COND  = 32'h0000_1400;
    localparam fetch_pkg::pc_t P_JUMP  = 32'h0000_1208;  // btb idx 2
    localparam fetch_pkg::pc_t T_JUMP  = 32'h0000_1800;
    localparam fetch_pkg::pc_t P_ALIAS = 32'h0000_1308;  // idx 2 with another tag
    localparam fetch_pkg::pc_t P_MP    = 32'h0000_1340;
    localparam fetch_pkg::pc_t T_MP    = 32'h0000_1600;

    typedef struct {
        string                   name;
        logic                    stall;
        bp_state_pkg::resolve_t  res;
        int                      chk;
    } row_t;

    logic                    clk;
    logic                    rst;
    logic                    stall;
    bp_state_pkg::resolve_t  resolve;
    fetch_pkg::pc_t          fetch_pc;
    bp_state_pkg::pred_t     pred;

    row_t   rows [$];
    int     n_rows;
    int     pc_errs;
    int     pred_errs;
    integer seed;

    // reference model state
    bp_state_pkg::ctr_t   m_ctr    [BHT_N];
    bit                   m_bht_v  [BHT_N];
    fetch_pkg::pc_t       m_btb_pc [BTB_N];     // whole branch pc, upper bits act as tag
    fetch_pkg::pc_t       m_tgt    [BTB_N];
    fetch_pkg::br_kind_t  m_kind   [BTB_N];
    bit                   m_btb_v  [BTB_N];
    fetch_pkg::pc_t       m_pc;                 // expected fetch pc

    branch_predictor u_dut (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .resolve  (resolve),
        .fetch_pc (fetch_pc),
        .pred     (pred)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;   // 10 ns period

    function automatic bp_state_pkg::resolve_t make_resolve(
        input fetch_pkg::pc_t pc, input fetch_pkg::br_kind_t kind, input logic taken,
        input fetch_pkg::pc_t target, input logic p_taken, input fetch_pkg::pc_t p_target);
        bp_state_pkg::resolve_t r;
        r.valid       = 1'b1;
        r.pc          = pc;
        r.kind        = kind;
        r.taken       = taken;
        r.target      = target;
        r.pred_taken  = p_taken;
        r.pred_target = p_target;
        return r;
    endfunction

    // non-branch guessed not taken that went to addr, so the tables stay untouched
    function automatic bp_state_pkg::resolve_t steer_to(input fetch_pkg::pc_t addr);
        return make_resolve(32'h0000_3000, fetch_pkg::br_none, 1'b1, addr, 1'b0, 32'h0);
    endfunction

    function automatic void push_row(input string name, input logic stl,
                                     input bp_state_pkg::resolve_t res, input int chk);
        row_t row;
        row.name  = name;
        row.stall = stl;
        row.res   = res;
        row.chk   = chk;
        rows.push_back(row);
    endfunction

    // saturating step counted as 0..3
    function automatic bp_state_pkg::ctr_t ctr_step(input bp_state_pkg::ctr_t c,
                                                    input logic taken);
        logic [1:0] v;
        v = c;
        if (taken && v != 2'b11) begin
            v = v + 2'd1;
        end else if (!taken && v != 2'b00) begin
            v = v - 2'd1;
        end
        return bp_state_pkg::ctr_t'(v);
    endfunction

    function automatic bp_state_pkg::pred_t model_pred(input fetch_pkg::pc_t pc);
        bp_state_pkg::pred_t p;
        bp_state_pkg::ctr_t  c;
        logic [7:0]          bi;
        logic [5:0]          ti;
        bi       = pc[9:2];
        ti       = pc[7:2];
        c        = m_bht_v[bi] ? m_ctr[bi] : bp_state_pkg::ctr_wnt;   // cold is weak nt
        p.taken  = 1'b0;
        p.target = pc + 32'd4;
        if (m_btb_v[ti] && m_btb_pc[ti][31:8] == pc[31:8]) begin
            if (m_kind[ti] == fetch_pkg::br_jump ||
                (m_kind[ti] == fetch_pkg::br_cond && c[1])) begin
                p.taken  = 1'b1;
                p.target = m_tgt[ti];
            end
        end
        return p;
    endfunction

    function automatic fetch_pkg::pc_t model_next_pc(input fetch_pkg::pc_t pc, input logic stl,
        input bp_state_pkg::resolve_t res, input bp_state_pkg::pred_t p);
        logic mp;
        mp = res.valid && ((res.taken != res.pred_taken) ||
                           (res.taken && res.target != res.pred_target));
        if (mp) begin
            return res.taken ? res.target : res.pc + 32'd4;  // redirect beats stall
        end
        if (stl) begin
            return pc;
        end
        if (p.taken) begin
            return p.target;
        end
        return pc + 32'd4;
    endfunction

    function automatic void model_update(input bp_state_pkg::resolve_t res);
        logic [7:0] bi;
        logic [5:0] ti;
        bi = res.pc[9:2];
        ti = res.pc[7:2];
        if (res.valid && res.kind == fetch_pkg::br_cond) begin
            m_ctr[bi]   = ctr_step(m_bht_v[bi] ? m_ctr[bi] : bp_state_pkg::ctr_wnt, res.taken);
            m_bht_v[bi] = 1'b1;
        end
        if (res.valid && (res.kind == fetch_pkg::br_jump ||
                          (res.kind == fetch_pkg::br_cond && res.taken))) begin
            m_btb_pc[ti] = res.pc;
            m_tgt[ti]    = res.target;
            m_kind[ti]   = res.kind;
            m_btb_v[ti]  = 1'b1;
        end
    endfunction

    task automatic check_pc(input string step, input fetch_pkg::pc_t exp_pc,
                            input fetch_pkg::pc_t act_pc);
        if (act_pc !== exp_pc) begin
            pc_errs++;
            $display("FAILED %s: fetch_pc expected %h actual %h", step, exp_pc, act_pc);
        end
    endtask

    task automatic check_pred(input string step, input bp_state_pkg::pred_t exp_p,
                              input bp_state_pkg::pred_t act_p);
        if (act_p !== exp_p) begin
            pred_errs++;
            $display("FAILED %s: pred expected taken=%b target=%h actual taken=%b target=%h",
                     step, exp_p.taken, exp_p.target, act_p.taken, act_p.target);
        end
    endtask

    task automatic build_directed();
        bp_state_pkg::resolve_t idle;
        idle = '0;
        push_row("reset",   1'b0, idle, CHK_ALL);
        push_row("seq_a",   1'b0, idle, CHK_PC);
        push_row("seq_b",   1'b0, idle, CHK_PC);
        push_row("stall_a", 1'b1, idle, CHK_PC);
        push_row("stall_b", 1'b1, idle, CHK_PC);
        push_row("seq_c",   1'b0, idle, CHK_ALL);
        // train toward taken and guessed right so no redirect
        push_row("cond_t1", 1'b0,
                 make_resolve(P_COND, fetch_pkg::br_cond, 1'b1, T_COND, 1'b1, T_COND), CHK_ALL);
        push_row("cond_t2", 1'b0,
                 make_resolve(P_COND, fetch_pkg::br_cond, 1'b1, T_COND, 1'b1, T_COND), CHK_ALL);
        push_row("cond_t3", 1'b0,
                 make_resolve(P_COND, fetch_pkg::br_cond, 1'b1, T_COND, 1'b1, T_COND), CHK_ALL);
        push_row("steer_p1", 1'b0, steer_to(P_COND), CHK_ALL);
        push_row("look_p1",  1'b0, idle, CHK_ALL);
        // walk back down one step per look
        push_row("cond_n1", 1'b0,
                 make_resolve(P_COND, fetch_pkg::br_cond, 1'b0, T_COND, 1'b0, T_COND), CHK_ALL);
        push_row("steer_p2", 1'b0, steer_to(P_COND), CHK_ALL);
        push_row("look_p2",  1'b0, idle, CHK_ALL);
        push_row("cond_n2", 1'b0,
                 make_resolve(P_COND, fetch_pkg::br_cond, 1'b0, T_COND, 1'b0, T_COND), CHK_ALL);
        push_row("steer_p3", 1'b0, steer_to(P_COND), CHK_ALL);
        push_row("look_p3",  1'b0, idle, CHK_ALL);
        push_row("cond_n3", 1'b0,
                 make_resolve(P_COND, fetch_pkg::br_cond, 1'b0, T_COND, 1'b0, T_COND), CHK_ALL);
        push_row("steer_p4", 1'b0, steer_to(P_COND), CHK_ALL);
        push_row("look_p4",  1'b0, idle, CHK_ALL);
        // floor saturates so one taken step stays below weak taken
        push_row("cond_n4", 1'b0,
                 make_resolve(P_COND, fetch_pkg::br_cond, 1'b0, T_COND, 1'b0, T_COND), CHK_ALL);
        push_row("cond_t4", 1'b0,
                 make_resolve(P_COND, fetch_pkg::br_cond, 1'b1, T_COND, 1'b1, T_COND), CHK_ALL);
        push_row("steer_p5", 1'b0, steer_to(P_COND), CHK_ALL);
        push_row("look_p5",  1'b0, idle, CHK_ALL);
        // jump needs no counter training
        push_row("jump_1", 1'b0,
                 make_resolve(P_JUMP, fetch_pkg::br_jump, 1'b1, T_JUMP, 1'b1, T_JUMP), CHK_ALL);
        push_row("steer_j",    1'b0, steer_to(P_JUMP), CHK_ALL);
        push_row("look_j",     1'b0, idle, CHK_ALL);
        push_row("steer_alias", 1'b0, steer_to(P_ALIAS), CHK_ALL);
        push_row("look_alias", 1'b0, idle, CHK_ALL);
        // redirect while stalled and then a correct guess
        push_row("mp_stall", 1'b1, make_resolve(P_MP, fetch_pkg::br_cond, 1'b1, T_MP, 1'b0,
                 P_MP + 32'd4), CHK_ALL);
        push_row("mp_land",  1'b1, idle, CHK_ALL);
        push_row("mp_hold",  1'b1, idle, CHK_PC);
        push_row("match_nt", 1'b0, make_resolve(P_MP + 32'd4, fetch_pkg::br_cond, 1'b0, T_MP,
                 1'b0, P_MP + 32'd8), CHK_ALL);
        push_row("match_seq", 1'b0, idle, CHK_ALL);
    endtask

    task automatic build_random();
        logic [31:0]            r;
        logic [31:0]            t;
        fetch_pkg::br_kind_t    kind;
        logic                   taken;
        bp_state_pkg::resolve_t res;
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            t = $random(seed);
            case (r[9:8])
                2'b00:   kind = fetch_pkg::br_none;
                2'b11:   kind = fetch_pkg::br_jump;
                default: kind = fetch_pkg::br_cond;
            endcase
            taken = (kind == fetch_pkg::br_jump) || (kind == fetch_pkg::br_cond && r[10]);
            // pcs packed into 0x1000..0x13fc so btb indices alias
            res = make_resolve(32'h0000_1000 + {22'd0, r[7:0], 2'b00}, kind, taken,
                               32'h0000_1000 + {22'd0, t[7:0], 2'b00}, r[11],
                               32'h0000_1000 + {22'd0, (r[12] ? t[7:0] : t[15:8]), 2'b00});
            res.valid = r[13] | r[14];
            push_row($sformatf("rand_%0d", i), r[15] & r[16], res, CHK_ALL);
        end
    endtask

    // watchdog budget scales with the table
    initial begin
        wait (n_rows > 0);
        #(n_rows * 4 * 10 * 2);
        $display("ERROR: watchdog expired, the run hung before finishing %0d rows", n_rows);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        bp_state_pkg::pred_t exp_pred;
        rst       = 1'b1;
        stall     = 1'b0;
        resolve   = '0;
        pc_errs   = 0;
        pred_errs = 0;
        seed      = 87;
        n_rows    = 0;
        for (int i = 0; i < BHT_N; i++) begin
            m_bht_v[i] = 1'b0;
        end
        for (int i = 0; i < BTB_N; i++) begin
            m_btb_v[i] = 1'b0;
        end
        m_pc = fetch_pkg::RESET_PC;
        build_directed();
        build_random();
        n_rows = rows.size();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (rows[i]) begin
            exp_pred = model_pred(m_pc);
            if (rows[i].chk != CHK_NONE) begin
                check_pc(rows[i].name, m_pc, fetch_pc);
            end
            if (rows[i].chk == CHK_ALL) begin
                check_pred(rows[i].name, exp_pred, pred);
            end
            stall   = rows[i].stall;
            resolve = rows[i].res;
            m_pc    = model_next_pc(m_pc, rows[i].stall, rows[i].res, exp_pred);
            model_update(rows[i].res);     // tables move at the same edge
            @(negedge clk);
        end
        stall   = 1'b0;
        resolve = '0;
        check_pc("final", m_pc, fetch_pc);
        check_pred("final", model_pred(m_pc), pred);

        $display("errors: fetch_pc %0d, pred %0d, total %0d",
                 pc_errs, pred_errs, pc_errs + pred_errs);
        if (pc_errs + pred_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
